//--- compile.f
src/spvacc_pkg.sv
src/wb_host_port.sv
src/vector_regfile.sv
src/nonzero_scan_pe.sv
src/sparse_control.sv
src/iter_accumulator.sv
src/spvacc_top.sv
testbench/spvacc_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module spvacc_tb -o spvacc_sim
./obj_dir/spvacc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

//--- src/iter_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module iter_accumulator #(
    parameter int data_w = spvacc_pkg::DATA_W,
    parameter int addr_w = spvacc_pkg::ADDR_W
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     en_ITR_sp,
    input  logic [addr_w-1:0]        vr_addr_sp,
    input  logic [addr_w-1:0]        vr_addr1,
    input  logic [addr_w:0]          vec_len,
    output logic [addr_w-1:0]        acc_raddr,
    input  logic [data_w-1:0]        acc_rdata,
    output logic [data_w+addr_w-1:0] acc_sum,
    output logic                     ITR_threshold_sp
);

    logic              run;
    logic              pend;
    logic              issuing;
    logic [addr_w:0]   ptr_ext;
    logic [addr_w:0]   end_ext;
    logic [addr_w-1:0] offset;

    // Pointers carry one extra bit so a wrapped range still compares correctly
    assign offset  = vr_addr_sp - vr_addr1;
    assign issuing = run && (ptr_ext != end_ext);

    assign acc_raddr = ptr_ext[addr_w-1:0];

    // Final once nothing is issued and nothing is in flight
    assign ITR_threshold_sp = run && !issuing && !pend;

    always_ff @(posedge clk) begin
        if (rst) begin
            run  <= 1'b0;
            pend <= 1'b0;
        end else begin
            pend <= issuing;
            if (en_ITR_sp) begin
                run <= 1'b1;
            end else if (ITR_threshold_sp) begin
                run <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_ITR_sp) begin
            ptr_ext <= {1'b0, vr_addr1} + {1'b0, offset};
            end_ext <= {1'b0, vr_addr1} + vec_len;
        end else if (issuing) begin
            ptr_ext <= ptr_ext + 1'b1;
        end
    end

    // Elements are unsigned and zero extended into the sum
    always_ff @(posedge clk) begin
        if (en_ITR_sp) begin
            acc_sum <= '0;
        end else if (pend) begin
            acc_sum <= acc_sum + {{addr_w{1'b0}}, acc_rdata};
        end
    end

    // Threshold only while running, and the run ends on the next cycle
    a_thr_in_run: assert property (@(posedge clk) disable iff (rst)
        ITR_threshold_sp |-> run ##1 !run);

endmodule

`default_nettype wire

//--- src/nonzero_scan_pe.sv
`timescale 1ns/1ps
`default_nettype none

module nonzero_scan_pe #(
    parameter int data_w = spvacc_pkg::DATA_W,
    parameter int addr_w = spvacc_pkg::ADDR_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              is_spvacc_xv,
    input  logic [addr_w-1:0] vr_addr1,
    input  logic [addr_w:0]   vec_len,
    output logic [addr_w-1:0] scan_raddr,
    input  logic [data_w-1:0] scan_rdata,
    output logic              tvalid_PE,
    output logic [addr_w:0]   tdata_PE
);
    import spvacc_pkg::*;

    scan_state_t       state;
    logic [addr_w-1:0] rd_ptr;
    logic [addr_w:0]   chk_idx;
    logic [addr_w:0]   len_q;
    logic              hit;

    // Length is checked first so data past the vector end is never looked at
    assign hit = (chk_idx == len_q) || (scan_rdata != '0);

    assign scan_raddr = rd_ptr;
    assign tvalid_PE  = (state == SCAN_CHECK) && hit;
    assign tdata_PE   = chk_idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SCAN_IDLE;
        end else begin
            case (state)
                SCAN_IDLE:  if (is_spvacc_xv) state <= SCAN_READ;
                SCAN_READ:  state <= SCAN_CHECK;
                SCAN_CHECK: if (hit) state <= SCAN_IDLE;
                default:    state <= SCAN_IDLE;
            endcase
        end
    end

    // Read address runs one element ahead of the checked offset
    always_ff @(posedge clk) begin
        case (state)
            SCAN_IDLE: begin
                rd_ptr  <= vr_addr1;
                len_q   <= vec_len;
                chk_idx <= '0;
            end
            SCAN_READ: begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            default: begin
                rd_ptr  <= rd_ptr + 1'b1;
                chk_idx <= chk_idx + 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/sparse_control.sv
`timescale 1ns/1ps
`default_nettype none

module sparse_control #(
    parameter int addr_w = spvacc_pkg::ADDR_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              is_spvacc_xv,
    input  logic [addr_w-1:0] vr_addr1,
    input  logic              tvalid_PE,
    input  logic [addr_w:0]   tdata_PE,
    input  logic              ITR_threshold_sp,
    output logic [addr_w-1:0] ITR_sp,
    output logic              wen_ITR_sp,
    output logic              en_ITR_sp,
    output logic [addr_w-1:0] vr_addr_sp
);
    import spvacc_pkg::*;

    ctl_state_t        state;
    ctl_state_t        next_state;
    logic [addr_w-1:0] skip_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CTL_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            CTL_IDLE:    if (is_spvacc_xv) next_state = CTL_WAIT_PE;
            CTL_WAIT_PE: if (tvalid_PE) next_state = CTL_RUN;
            CTL_RUN:     if (ITR_threshold_sp) next_state = CTL_IDLE;
            default:     next_state = CTL_IDLE;
        endcase
    end

    // Start the accumulator on the scanner result
    assign en_ITR_sp = (state == CTL_WAIT_PE) && tvalid_PE;

    // First nonzero address, taken straight from the scanner offset
    assign vr_addr_sp = vr_addr1 + tdata_PE[addr_w-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            wen_ITR_sp <= 1'b0;
        end else begin
            wen_ITR_sp <= en_ITR_sp;
        end
    end

    always_ff @(posedge clk) begin
        if (en_ITR_sp) begin
            skip_q <= tdata_PE[addr_w-1:0];
        end
    end

    // Offset minus one, wraps to all ones for k = 0
    assign ITR_sp = skip_q - 1'b1;

    // Scanner result only arrives while the FSM waits for it
    a_pe_in_wait: assert property (@(posedge clk) disable iff (rst)
        tvalid_PE |-> (state == CTL_WAIT_PE));

endmodule

`default_nettype wire

//--- src/spvacc_pkg.sv
`default_nettype none

package spvacc_pkg;

    // Element and address widths
    localparam int DATA_W = 16;
    localparam int ADDR_W = 6;
    localparam int ACC_W  = DATA_W + ADDR_W;

    // Wishbone word address, top bit selects the element memory
    localparam int WB_AW = 8;

    // Register map (word offsets)
    localparam int REG_BASE   = 0;
    localparam int REG_LEN    = 1;
    localparam int REG_CMD    = 2;
    localparam int REG_STATUS = 3;
    localparam int REG_SUM    = 4;
    localparam int REG_SKIP   = 5;

    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,
        OP_SPVACC = 2'd1
    } opcode_t;

    typedef enum logic [1:0] {
        CTL_IDLE    = 2'd0,
        CTL_WAIT_PE = 2'd1,
        CTL_RUN     = 2'd2
    } ctl_state_t;

    typedef enum logic [1:0] {
        SCAN_IDLE  = 2'd0,
        SCAN_READ  = 2'd1,
        SCAN_CHECK = 2'd2
    } scan_state_t;

endpackage

`default_nettype wire

//--- src/spvacc_top.sv
`timescale 1ns/1ps
`default_nettype none

module spvacc_top #(
    parameter int data_w = spvacc_pkg::DATA_W,
    parameter int addr_w = spvacc_pkg::ADDR_W
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [spvacc_pkg::WB_AW-1:0] wb_adr,
    input  logic [31:0]                  wb_dat_w,
    output logic [31:0]                  wb_dat_r,
    output logic                         wb_ack
);

    localparam int acc_w = data_w + addr_w;

    logic              mem_we;
    logic [addr_w-1:0] mem_waddr;
    logic [data_w-1:0] mem_wdata;
    logic [addr_w-1:0] scan_raddr;
    logic [data_w-1:0] scan_rdata;
    logic [addr_w-1:0] acc_raddr;
    logic [data_w-1:0] acc_rdata;
    logic              is_spvacc_xv;
    logic [addr_w-1:0] vr_addr1;
    logic [addr_w:0]   vec_len;
    logic              tvalid_PE;
    logic [addr_w:0]   tdata_PE;
    logic [addr_w-1:0] ITR_sp;
    logic              wen_ITR_sp;
    logic              en_ITR_sp;
    logic [addr_w-1:0] vr_addr_sp;
    logic [acc_w-1:0]  acc_sum;
    logic              ITR_threshold_sp;

    wb_host_port #(.data_w(data_w), .addr_w(addr_w)) wb_host_port_inst (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
        .is_spvacc_xv(is_spvacc_xv), .vr_addr1(vr_addr1), .vec_len(vec_len),
        .ITR_sp(ITR_sp), .wen_ITR_sp(wen_ITR_sp), .acc_sum(acc_sum),
        .ITR_threshold_sp(ITR_threshold_sp)
    );

    vector_regfile #(.data_w(data_w), .addr_w(addr_w)) vector_regfile_inst (
        .clk(clk), .mem_we(mem_we), .mem_waddr(mem_waddr), .mem_wdata(mem_wdata),
        .scan_raddr(scan_raddr), .scan_rdata(scan_rdata),
        .acc_raddr(acc_raddr), .acc_rdata(acc_rdata)
    );

    nonzero_scan_pe #(.data_w(data_w), .addr_w(addr_w)) nonzero_scan_pe_inst (
        .clk(clk), .rst(rst), .is_spvacc_xv(is_spvacc_xv), .vr_addr1(vr_addr1),
        .vec_len(vec_len), .scan_raddr(scan_raddr), .scan_rdata(scan_rdata),
        .tvalid_PE(tvalid_PE), .tdata_PE(tdata_PE)
    );

    sparse_control #(.addr_w(addr_w)) sparse_control_inst (
        .clk(clk), .rst(rst), .is_spvacc_xv(is_spvacc_xv), .vr_addr1(vr_addr1),
        .tvalid_PE(tvalid_PE), .tdata_PE(tdata_PE), .ITR_threshold_sp(ITR_threshold_sp),
        .ITR_sp(ITR_sp), .wen_ITR_sp(wen_ITR_sp), .en_ITR_sp(en_ITR_sp),
        .vr_addr_sp(vr_addr_sp)
    );

    iter_accumulator #(.data_w(data_w), .addr_w(addr_w)) iter_accumulator_inst (
        .clk(clk), .rst(rst), .en_ITR_sp(en_ITR_sp), .vr_addr_sp(vr_addr_sp),
        .vr_addr1(vr_addr1), .vec_len(vec_len), .acc_raddr(acc_raddr),
        .acc_rdata(acc_rdata), .acc_sum(acc_sum), .ITR_threshold_sp(ITR_threshold_sp)
    );

endmodule

`default_nettype wire

//--- src/vector_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module vector_regfile #(
    parameter int data_w = spvacc_pkg::DATA_W,
    parameter int addr_w = spvacc_pkg::ADDR_W
) (
    input  logic              clk,
    input  logic              mem_we,
    input  logic [addr_w-1:0] mem_waddr,
    input  logic [data_w-1:0] mem_wdata,
    input  logic [addr_w-1:0] scan_raddr,
    output logic [data_w-1:0] scan_rdata,
    input  logic [addr_w-1:0] acc_raddr,
    output logic [data_w-1:0] acc_rdata
);

    localparam int depth = 2 ** addr_w;

    logic [data_w-1:0] mem [0:depth-1];

    // Host write port
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    // Scanner read port, one cycle latency
    always_ff @(posedge clk) begin
        scan_rdata <= mem[scan_raddr];
    end

    // Accumulator read port, one cycle latency
    always_ff @(posedge clk) begin
        acc_rdata <= mem[acc_raddr];
    end

endmodule

`default_nettype wire

//--- src/wb_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module wb_host_port #(
    parameter int data_w = spvacc_pkg::DATA_W,
    parameter int addr_w = spvacc_pkg::ADDR_W
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wb_cyc,
    input  logic                       wb_stb,
    input  logic                       wb_we,
    input  logic [spvacc_pkg::WB_AW-1:0] wb_adr,
    input  logic [31:0]                wb_dat_w,
    output logic [31:0]                wb_dat_r,
    output logic                       wb_ack,
    output logic                       mem_we,
    output logic [addr_w-1:0]          mem_waddr,
    output logic [data_w-1:0]          mem_wdata,
    output logic                       is_spvacc_xv,
    output logic [addr_w-1:0]          vr_addr1,
    output logic [addr_w:0]            vec_len,
    input  logic [addr_w-1:0]          ITR_sp,
    input  logic                       wen_ITR_sp,
    input  logic [data_w+addr_w-1:0]   acc_sum,
    input  logic                       ITR_threshold_sp
);
    import spvacc_pkg::*;

    logic                     req;
    logic                     mem_sel;
    logic                     reg_wr;
    logic                     start;
    logic [WB_AW-2:0]         reg_idx;
    opcode_t                  cmd_op;
    logic [31:0]              rd_mux;
    logic [addr_w-1:0]        base_q;
    logic [addr_w:0]          len_q;
    logic                     busy;
    logic                     done;
    logic [data_w+addr_w-1:0] sum_q;
    logic [addr_w-1:0]        skip_q;

    // New access on every strobe that has not been acked yet
    assign req     = wb_cyc && wb_stb && !wb_ack;
    assign mem_sel = wb_adr[WB_AW-1];
    assign reg_idx = wb_adr[WB_AW-2:0];
    assign reg_wr  = req && wb_we && !mem_sel;
    assign cmd_op  = opcode_t'(wb_dat_w[1:0]);

    // A command while busy is acked but ignored
    assign start = reg_wr && (reg_idx == REG_CMD) && (cmd_op == OP_SPVACC) && !busy;

    assign mem_we    = req && wb_we && mem_sel;
    assign mem_waddr = wb_adr[addr_w-1:0];
    assign mem_wdata = wb_dat_w[data_w-1:0];

    assign vr_addr1 = base_q;
    assign vec_len  = len_q;

    always_comb begin
        rd_mux = '0;
        if (!mem_sel) begin
            case (reg_idx)
                REG_BASE:   rd_mux[addr_w-1:0] = base_q;
                REG_LEN:    rd_mux[addr_w:0] = len_q;
                REG_STATUS: rd_mux[1:0] = {done, busy};
                REG_SUM:    rd_mux[data_w+addr_w-1:0] = sum_q;
                REG_SKIP:   rd_mux[addr_w-1:0] = skip_q;
                default:    rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack       <= 1'b0;
            is_spvacc_xv <= 1'b0;
            base_q       <= '0;
            len_q        <= '0;
            busy         <= 1'b0;
            done         <= 1'b0;
        end else begin
            wb_ack       <= req;
            is_spvacc_xv <= start;
            if (reg_wr && reg_idx == REG_BASE) begin
                base_q <= wb_dat_w[addr_w-1:0];
            end
            if (reg_wr && reg_idx == REG_LEN) begin
                len_q <= wb_dat_w[addr_w:0];
            end
            // Done stays up until the next accepted command
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (ITR_threshold_sp) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_mux;
        end
        if (wen_ITR_sp) begin
            skip_q <= ITR_sp;
        end
        if (ITR_threshold_sp) begin
            sum_q <= acc_sum;
        end
    end

    // Results only come back for an accepted command
    a_result_while_busy: assert property (@(posedge clk) disable iff (rst)
        (wen_ITR_sp || ITR_threshold_sp) |-> busy);

endmodule

`default_nettype wire

//--- testbench/spvacc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module spvacc_tb;
    import spvacc_pkg::*;

    localparam int DEPTH       = 1 << ADDR_W;
    localparam int N_TESTS     = 25;
    localparam int CYCLE_LIMIT = N_TESTS * (2 * 64 + 40);

    logic                 clk;
    logic                 rst;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_AW-1:0]     wb_adr;
    logic [31:0]          wb_dat_w;
    logic [31:0]          wb_dat_r;
    logic                 wb_ack;

    logic [DATA_W-1:0]    tb_mem [0:DEPTH-1];
    integer               seed;
    int                   errors;
    int                   checks;
    int                   cycles;

    spvacc_top #(.data_w(DATA_W), .addr_w(ADDR_W)) spvacc_top_inst (
        .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Ack comes on the edge after the strobe, data is sampled just after that edge
    task automatic wait_ack();
        do begin
            @(posedge clk);
            #1;
        end while (!wb_ack);
    endtask

    task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [31:0] data);
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        wait_ack();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [31:0] data);
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        wait_ack();
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    // Expected results from the local copy of the element memory
    function automatic void ref_spvacc(input int base, input int len, output int k,
                                       output int skip, output longint sum);
        k   = len;
        sum = 0;
        for (int i = 0; i < len; i++) begin
            if (k == len && tb_mem[(base + i) % DEPTH] != '0) begin
                k = i;
            end
        end
        for (int i = k; i < len; i++) begin
            sum += longint'(tb_mem[(base + i) % DEPTH]);
        end
        sum  = sum % (longint'(1) << ACC_W);
        skip = (k + DEPTH - 1) % DEPTH;
    endfunction

    // Zero prefix, then random data whose first element is forced nonzero
    task automatic load_vector(input int base, input int len, input int zeros);
        logic [31:0] rnd;
        int          addr;
        for (int i = 0; i < len; i++) begin
            addr = (base + i) % DEPTH;
            rnd  = $random(seed);
            if (i < zeros) begin
                rnd = '0;
            end else if (i == zeros && rnd[DATA_W-1:0] == '0) begin
                rnd = 32'd1;
            end
            tb_mem[addr] = rnd[DATA_W-1:0];
            wb_write(WB_AW'((1 << (WB_AW - 1)) | addr), {16'h0, rnd[DATA_W-1:0]});
        end
    endtask

    task automatic start_cmd(input int base, input int len);
        wb_write(WB_AW'(REG_BASE), 32'(base));
        wb_write(WB_AW'(REG_LEN), 32'(len));
        wb_write(WB_AW'(REG_CMD), 32'(OP_SPVACC));
    endtask

    task automatic collect_and_check(input string name, input int base, input int len,
                                     output logic [31:0] act_sum,
                                     output logic [31:0] act_skip);
        logic [31:0] status;
        int          k;
        int          exp_skip;
        longint      exp_sum;
        do begin
            wb_read(WB_AW'(REG_STATUS), status);
        end while (!status[1]);
        ref_spvacc(base, len, k, exp_skip, exp_sum);
        wb_read(WB_AW'(REG_SUM), act_sum);
        check_value({name, " sum"}, exp_sum, act_sum);
        wb_read(WB_AW'(REG_SKIP), act_skip);
        check_value({name, " skip"}, exp_skip, act_skip);
    endtask

    task automatic run_test(input string name, input int base, input int len,
                            input int zeros);
        logic [31:0] act_sum;
        logic [31:0] act_skip;
        load_vector(base, len, zeros);
        start_cmd(base, len);
        collect_and_check(name, base, len, act_sum, act_skip);
    endtask

    initial begin
        logic [31:0] rdata;
        logic [31:0] act_sum;
        logic [31:0] act_skip;
        int          base;
        int          len;
        int          zeros;

        seed     = 32'hf6c1d5e7;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        zeros = 1 + ($unsigned($random(seed)) % 20);
        run_test("leading_zeros", 0, 40, zeros);

        // First element nonzero, skip wraps to all ones
        load_vector(3, 48, 0);
        start_cmd(3, 48);
        collect_and_check("no_leading_zeros", 3, 48, act_sum, act_skip);
        check_value("no_leading_zeros all ones", DEPTH - 1, act_skip);

        load_vector(10, 32, 32);
        start_cmd(10, 32);
        collect_and_check("all_zeros", 10, 32, act_sum, act_skip);
        check_value("all_zeros sum zero", 0, act_sum);
        check_value("all_zeros skip len-1", 31, act_skip);

        run_test("wrap_base", 56, 30, 4);

        // Second command lands while the first one is still running
        load_vector(20, 40, 7);
        start_cmd(20, 40);
        wb_read(WB_AW'(REG_STATUS), rdata);
        check_value("busy set after start", 1, rdata[0]);
        wb_write(WB_AW'(REG_CMD), 32'(OP_SPVACC));
        collect_and_check("busy_drop", 20, 40, act_sum, act_skip);
        repeat (10) @(posedge clk);
        wb_read(WB_AW'(REG_STATUS), rdata);
        check_value("busy_drop final status", 2, rdata);

        for (int t = 0; t < 20; t++) begin
            base  = $unsigned($random(seed)) % DEPTH;
            len   = 1 + ($unsigned($random(seed)) % 48);
            zeros = $unsigned($random(seed)) % (len + 1);
            run_test($sformatf("sweep_%0d", t), base, len, zeros);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
